//--- hostIf_consts.svh
`ifndef HOSTIF_CONSTS_SVH
`define HOSTIF_CONSTS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

// host wire and pipe word
`define HOST_WORD_W 16

// result register and one memory word
`define HOST_RESULT_W 32

// pulse memory addressing
`define MEM_ADDR_W 14
`define MEM_DEPTH (1 << `MEM_ADDR_W)

// host driven DIO lines
`define DIO_NUM 7

////////////////////////////////////////
// fixed system values
////////////////////////////////////////

// firmware build number also reported for date and time queries
`define FW_VERSION 32'd4215

// clocks in MHz
`define PP_CLK_MHZ 32'd60
`define DDS_CLK_MHZ 32'd60

// one bit per available module
`define MODULE_MASK 32'h0000001F

// answer for unknown group or opcode
`define ERR_WORD 32'hFFFFFFFF

`endif

//--- hostIfPkg.sv
`include "hostIf_consts.svh"

package hostIfPkg;

	////////////////////////////////////////
	// command encodings
	////////////////////////////////////////

	// command group, upper byte of the command wire
	typedef enum logic [7:0]
	{
		CMD_SYS = 8'h0,
		CMD_PPL = 8'h1,
		CMD_DIG = 8'h3
	} cmdGroupE;

	// system group opcodes
	typedef enum logic [7:0]
	{
		SYS_RESET  = 8'h0,
		SYS_PPCLK  = 8'h1,
		SYS_FWVER  = 8'h2,
		SYS_FWDATE = 8'h3,
		SYS_MODULE = 8'h4,
		SYS_FWTIME = 8'h5,
		SYS_DDSCLK = 8'h9
	} sysOpE;

	// pipeline memory opcodes
	typedef enum logic [7:0]
	{
		PPL_RESET = 8'h0,
		PPL_ADDR  = 8'h1
	} pplOpE;

	// digital output opcodes
	typedef enum logic [7:0]
	{
		DIG_WRITE = 8'h1,
		DIG_READ  = 8'h2
	} digOpE;

	// decoder loop
	typedef enum logic
	{
		DEC_IDLE = 1'b0,
		DEC_WAIT = 1'b1
	} decStateE;

	////////////////////////////////////////
	// bundles
	////////////////////////////////////////

	// full host command, 64 bits
	typedef struct packed
	{
		cmdGroupE group;
		logic [7:0] op;
		logic [`HOST_WORD_W-1:0] param;
		logic [`HOST_WORD_W-1:0] dataHigh;
		logic [`HOST_WORD_W-1:0] dataLow;
	} hostCmdT;

	// one memory write
	typedef struct packed
	{
		logic we;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`HOST_RESULT_W-1:0] data;
	} memWriteT;

	// pipe restart control, shared by both pipes
	typedef struct packed
	{
		logic restart;
		logic [`MEM_ADDR_W-1:0] startAddr;
	} pipeCtrlT;

endpackage

//--- hostCmdDecoder.sv
`include "hostIf_consts.svh"

module hostCmdDecoder
(
	input logic wUsbClk,
	input logic reset_i,
	input logic cmdTrig_i,
	input hostIfPkg::hostCmdT cmd_i,
	output logic [`HOST_RESULT_W-1:0] result_o,
	output logic [`DIO_NUM-1:0] shutter_o,
	output hostIfPkg::pipeCtrlT pipeCtrl_o
);

	// zero padding for short answers
	localparam int PAD_WORD_W = `HOST_RESULT_W - `HOST_WORD_W;
	localparam int PAD_DIO_W = `HOST_RESULT_W - `DIO_NUM;

	hostIfPkg::decStateE state;
	logic [`HOST_RESULT_W-1:0] resultReg;
	logic [`DIO_NUM-1:0] shutterReg;
	logic restartPulse;
	logic [`MEM_ADDR_W-1:0] startAddr;

	////////////////////////////////////////
	// command loop
	////////////////////////////////////////

	always_ff @(posedge wUsbClk)
	begin
		if (reset_i)
		begin
			state <= hostIfPkg::DEC_IDLE;
			resultReg <= '0;
			shutterReg <= '0;
			restartPulse <= 1'b0;
			startAddr <= '0;
		end
		else
		begin
			case (state)
			hostIfPkg::DEC_IDLE:
			begin
				// triggers only count here
				if (cmdTrig_i)
				begin
					case (cmd_i.group)
					hostIfPkg::CMD_SYS:
					begin
						// fixed values
						case (cmd_i.op)
						hostIfPkg::SYS_RESET: resultReg <= '0;
						hostIfPkg::SYS_PPCLK: resultReg <= `PP_CLK_MHZ;
						hostIfPkg::SYS_FWVER: resultReg <= `FW_VERSION;
						hostIfPkg::SYS_FWDATE: resultReg <= `FW_VERSION;
						hostIfPkg::SYS_MODULE: resultReg <= `MODULE_MASK;
						hostIfPkg::SYS_FWTIME: resultReg <= `FW_VERSION;
						hostIfPkg::SYS_DDSCLK: resultReg <= `DDS_CLK_MHZ;
						default: resultReg <= `ERR_WORD;
						endcase
					end
					hostIfPkg::CMD_PPL:
					begin
						case (cmd_i.op)
						hostIfPkg::PPL_RESET:
						begin
							// pipes back to address zero, answer kept
							startAddr <= '0;
							restartPulse <= 1'b1;
							state <= hostIfPkg::DEC_WAIT;
						end
						hostIfPkg::PPL_ADDR:
						begin
							startAddr <= cmd_i.dataLow[`MEM_ADDR_W-1:0];
							resultReg <= {{PAD_WORD_W{1'b0}}, cmd_i.dataLow};
							restartPulse <= 1'b1;
							state <= hostIfPkg::DEC_WAIT;
						end
						default: resultReg <= `ERR_WORD;
						endcase
					end
					hostIfPkg::CMD_DIG:
					begin
						case (cmd_i.op)
						// shutter update, result untouched
						hostIfPkg::DIG_WRITE: shutterReg <= cmd_i.dataLow[`DIO_NUM-1:0];
						hostIfPkg::DIG_READ: resultReg <= {{PAD_DIO_W{1'b0}}, shutterReg};
						default: resultReg <= `ERR_WORD;
						endcase
					end
					default:
					begin
						// unknown group
						resultReg <= `ERR_WORD;
					end
					endcase
				end
			end
			hostIfPkg::DEC_WAIT:
			begin
				// restart spans this single cycle
				restartPulse <= 1'b0;
				state <= hostIfPkg::DEC_IDLE;
			end
			default:
			begin
				state <= hostIfPkg::DEC_IDLE;
			end
			endcase
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	assign result_o = resultReg;
	assign shutter_o = shutterReg;
	assign pipeCtrl_o.restart = restartPulse;
	assign pipeCtrl_o.startAddr = startAddr;

endmodule

//--- pipeInPacker.sv
`include "hostIf_consts.svh"

module pipeInPacker
(
	input logic wUsbClk,
	input logic reset_i,
	input hostIfPkg::pipeCtrlT pipeCtrl_i,
	input logic write_i,
	input logic [`HOST_WORD_W-1:0] data_i,
	output hostIfPkg::memWriteT memWrite_o
);

	// high half expected next
	logic halfSel;
	// next word address, wraps at memory depth
	logic [`MEM_ADDR_W-1:0] wrAddr;
	// low half waiting for its partner
	logic [`HOST_WORD_W-1:0] lowHold;
	logic weReg;
	logic [`MEM_ADDR_W-1:0] addrReg;
	logic [`HOST_RESULT_W-1:0] dataReg;

	// toggle, address and write enable
	always_ff @(posedge wUsbClk)
	begin
		if (reset_i)
		begin
			halfSel <= 1'b0;
			wrAddr <= '0;
			weReg <= 1'b0;
		end
		else if (pipeCtrl_i.restart)
		begin
			halfSel <= 1'b0;
			wrAddr <= pipeCtrl_i.startAddr;
			weReg <= 1'b0;
		end
		else
		begin
			// write lands one cycle after the high half
			weReg <= write_i & halfSel;
			if (write_i)
			begin
				halfSel <= ~halfSel;
				if (halfSel)
				begin
					wrAddr <= wrAddr + 1'b1;
				end
			end
		end
	end

	// payload path
	always_ff @(posedge wUsbClk)
	begin
		if (write_i & ~halfSel)
		begin
			lowHold <= data_i;
		end
		if (write_i & halfSel)
		begin
			addrReg <= wrAddr;
			dataReg <= {data_i, lowHold};
		end
	end

	assign memWrite_o.we = weReg;
	assign memWrite_o.addr = addrReg;
	assign memWrite_o.data = dataReg;

endmodule

//--- pulseMemory.sv
`include "hostIf_consts.svh"

module pulseMemory
(
	input logic wUsbClk,
	input hostIfPkg::memWriteT memWrite_i,
	input logic [`MEM_ADDR_W-1:0] readAddr_i,
	output logic [`HOST_RESULT_W-1:0] readData_o
);

	////////////////////////////////////////
	// pulse program storage
	////////////////////////////////////////

	// one word per pulse program line
	logic [`HOST_RESULT_W-1:0] memArray [`MEM_DEPTH];

	// write port
	always_ff @(posedge wUsbClk)
	begin
		if (memWrite_i.we)
		begin
			memArray[memWrite_i.addr] <= memWrite_i.data;
		end
	end

	// read port, one cycle after the address
	always_ff @(posedge wUsbClk)
	begin
		readData_o <= memArray[readAddr_i];
	end

endmodule

//--- pipeOutUnpacker.sv
`include "hostIf_consts.svh"

module pipeOutUnpacker
(
	input logic wUsbClk,
	input logic reset_i,
	input hostIfPkg::pipeCtrlT pipeCtrl_i,
	input logic read_i,
	input logic [`HOST_RESULT_W-1:0] readData_i,
	output logic [`MEM_ADDR_W-1:0] readAddr_o,
	output logic [`HOST_WORD_W-1:0] data_o
);

	// word currently addressed in memory
	logic [`MEM_ADDR_W-1:0] rdAddr;
	// high half is up next
	logic halfSel;
	// upper half saved on the low read
	logic [`HOST_WORD_W-1:0] highHold;

	////////////////////////////////////////
	// read sequencing
	////////////////////////////////////////

	always_ff @(posedge wUsbClk)
	begin
		if (reset_i)
		begin
			rdAddr <= '0;
			halfSel <= 1'b0;
		end
		else if (pipeCtrl_i.restart)
		begin
			// first word shows two cycles later
			rdAddr <= pipeCtrl_i.startAddr;
			halfSel <= 1'b0;
		end
		else if (read_i)
		begin
			halfSel <= ~halfSel;
			// advance early so the next word is ready for the next low read
			if (!halfSel)
			begin
				rdAddr <= rdAddr + 1'b1;
			end
		end
	end

	// holding register
	always_ff @(posedge wUsbClk)
	begin
		if (read_i & ~halfSel)
		begin
			highHold <= readData_i[`HOST_RESULT_W-1:`HOST_WORD_W];
		end
	end

	////////////////////////////////////////
	// host side
	////////////////////////////////////////

	assign readAddr_o = rdAddr;
	// low half straight from memory, high half from the latch
	assign data_o = halfSel ? highHold : readData_i[`HOST_WORD_W-1:0];

endmodule

//--- hostCore.sv
`include "hostIf_consts.svh"

module hostCore
(
	input logic wUsbClk,
	input logic reset_i,
	input logic cmdTrig_i,
	input hostIfPkg::hostCmdT cmd_i,
	input logic pipeInWrite_i,
	input logic [`HOST_WORD_W-1:0] pipeInData_i,
	input logic pipeOutRead_i,
	output logic [`HOST_RESULT_W-1:0] result_o,
	output logic [`DIO_NUM-1:0] shutter_o,
	output logic [`HOST_WORD_W-1:0] pipeOutData_o
);

	// restart and start address to both pipes
	hostIfPkg::pipeCtrlT pipeCtrl;
	// packer to memory
	hostIfPkg::memWriteT memWrite;
	// unpacker side of the memory
	logic [`MEM_ADDR_W-1:0] memReadAddr;
	logic [`HOST_RESULT_W-1:0] memReadData;

	////////////////////////////////////////
	// command path
	////////////////////////////////////////

	hostCmdDecoder cmdDecoder0
	(
		.wUsbClk(wUsbClk),
		.reset_i(reset_i),
		.cmdTrig_i(cmdTrig_i),
		.cmd_i(cmd_i),
		.result_o(result_o),
		.shutter_o(shutter_o),
		.pipeCtrl_o(pipeCtrl)
	);

	////////////////////////////////////////
	// pipe data path
	////////////////////////////////////////

	pipeInPacker packer0
	(
		.wUsbClk(wUsbClk),
		.reset_i(reset_i),
		.pipeCtrl_i(pipeCtrl),
		.write_i(pipeInWrite_i),
		.data_i(pipeInData_i),
		.memWrite_o(memWrite)
	);

	pulseMemory memory0
	(
		.wUsbClk(wUsbClk),
		.memWrite_i(memWrite),
		.readAddr_i(memReadAddr),
		.readData_o(memReadData)
	);

	pipeOutUnpacker unpacker0
	(
		.wUsbClk(wUsbClk),
		.reset_i(reset_i),
		.pipeCtrl_i(pipeCtrl),
		.read_i(pipeOutRead_i),
		.readData_i(memReadData),
		.readAddr_o(memReadAddr),
		.data_o(pipeOutData_o)
	);

endmodule

//--- hostCore_assertions.sv
`include "hostIf_consts.svh"

module hostCoreAssertions
(
	input logic wUsbClk,
	input logic reset_i,
	input logic cmdTrig_i,
	input logic [`HOST_RESULT_W-1:0] result_i,
	input logic pipeInWrite_i,
	input logic restart_i,
	input logic memWe_i
);

	// assertion failures so far
	int failCount = 0;

	////////////////////////////////////////
	// protocol rules
	////////////////////////////////////////

	// restart only spans the WAIT cycle
	restartOnePulse: assert property (@(posedge wUsbClk) disable iff (reset_i)
		restart_i |=> !restart_i)
		else
		begin
			failCount++;
			$error("pipe restart high for two cycles");
		end

	// write follows the high half strobe
	writeAfterStrobe: assert property (@(posedge wUsbClk) disable iff (reset_i)
		memWe_i |-> $past(pipeInWrite_i))
		else
		begin
			failCount++;
			$error("memory write without a pipe strobe the cycle before");
		end

	// answer moves only after a trigger
	resultNeedsTrigger: assert property (@(posedge wUsbClk) disable iff (reset_i)
		!$stable(result_i) |-> $past(cmdTrig_i))
		else
		begin
			failCount++;
			$error("result changed without a trigger");
		end

endmodule

bind hostCore hostCoreAssertions assert0
(
	.wUsbClk(wUsbClk),
	.reset_i(reset_i),
	.cmdTrig_i(cmdTrig_i),
	.result_i(result_o),
	.pipeInWrite_i(pipeInWrite_i),
	.restart_i(pipeCtrl.restart),
	.memWe_i(memWrite.we)
);

//--- hostCore_tb.sv
`include "hostIf_consts.svh"

module hostCore_tb;

	localparam int PIPE_WORDS = 16;
	localparam int RESTART_TIMEOUT = 8;

	logic wUsbClk;
	logic reset_i;
	logic cmdTrig_i;
	hostIfPkg::hostCmdT cmd_i;
	logic pipeInWrite_i;
	logic [`HOST_WORD_W-1:0] pipeInData_i;
	logic pipeOutRead_i;
	logic [`HOST_RESULT_W-1:0] result_o;
	logic [`DIO_NUM-1:0] shutter_o;
	logic [`HOST_WORD_W-1:0] pipeOutData_o;

	int errorCount;
	int checkCount;
	logic [31:0] lcgState;

	// command table with one expected answer per entry
	hostIfPkg::hostCmdT cmdTable[$];
	logic [`HOST_RESULT_W-1:0] expResult[$];
	logic [`DIO_NUM-1:0] expShutter[$];

	// host words for the pipe round trip
	logic [`HOST_WORD_W-1:0] pipeWords [PIPE_WORDS];

	hostCore dut0
	(
		.wUsbClk(wUsbClk),
		.reset_i(reset_i),
		.cmdTrig_i(cmdTrig_i),
		.cmd_i(cmd_i),
		.pipeInWrite_i(pipeInWrite_i),
		.pipeInData_i(pipeInData_i),
		.pipeOutRead_i(pipeOutRead_i),
		.result_o(result_o),
		.shutter_o(shutter_o),
		.pipeOutData_o(pipeOutData_o)
	);

	initial
	begin
		wUsbClk = 1'b0;
	end

	always #20 wUsbClk = ~wUsbClk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// preload pattern unique per address
	function automatic logic [31:0] fillWord(input logic [`MEM_ADDR_W-1:0] addr);
		return {2'b10, addr, 2'b01, ~addr};
	endfunction

	function automatic hostIfPkg::hostCmdT makeCmd(input logic [7:0] group,
		input logic [7:0] op, input logic [15:0] dataLow);
		hostIfPkg::hostCmdT cmd;
		cmd.group = hostIfPkg::cmdGroupE'(group);
		cmd.op = op;
		cmd.param = '0;
		cmd.dataHigh = '0;
		cmd.dataLow = dataLow;
		return cmd;
	endfunction

	task automatic addEntry(input hostIfPkg::hostCmdT cmd,
		input logic [31:0] result, input logic [`DIO_NUM-1:0] shutter);
		cmdTable.push_back(cmd);
		expResult.push_back(result);
		expShutter.push_back(shutter);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	// each step lands just after a rising edge
	task automatic waitCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge wUsbClk);
			#2;
		end
	endtask

	// one cycle trigger that returns after the accepting edge
	task automatic pulseTrigger(input hostIfPkg::hostCmdT cmd);
		cmdTrig_i = 1'b1;
		cmd_i = cmd;
		waitCycles(1);
		cmdTrig_i = 1'b0;
	endtask

	task automatic runCommand(input hostIfPkg::hostCmdT cmd,
		input logic [31:0] result, input logic [`DIO_NUM-1:0] shutter);
		pulseTrigger(cmd);
		checkValue("result_o", result_o, result);
		checkValue("shutter_o", 32'(shutter_o), 32'(shutter));
		// second cycle of the command spacing
		waitCycles(1);
	endtask

	task automatic waitRestartEnd();
		int guard;
		guard = 0;
		while (dut0.pipeCtrl.restart !== 1'b0 && guard < RESTART_TIMEOUT)
		begin
			waitCycles(1);
			guard++;
		end
		if (dut0.pipeCtrl.restart !== 1'b0)
		begin
			errorCount++;
			$display("Timeout: pipe restart still high after %0d cycles", guard);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial
	begin
		hostIfPkg::hostCmdT pplCmd;
		logic [31:0] rand32;
		logic [31:0] word;
		logic [15:0] dioValue;
		logic [`MEM_ADDR_W-1:0] startAddr;
		logic [`MEM_ADDR_W-1:0] secondAddr;

		errorCount = 0;
		checkCount = 0;
		lcgState = 32'h4b025cc0;
		reset_i = 1'b1;
		cmdTrig_i = 1'b0;
		cmd_i = '0;
		pipeInWrite_i = 1'b0;
		pipeInData_i = '0;
		pipeOutRead_i = 1'b0;

		// known memory contents before the first edge
		for (int a = 0; a < `MEM_DEPTH; a++)
		begin
			dut0.memory0.memArray[a] = fillWord(a[`MEM_ADDR_W-1:0]);
		end

		repeat (4) @(posedge wUsbClk);
		#2;
		reset_i = 1'b0;

		// after reset the unpacker shows the low half of word zero
		word = fillWord('0);
		checkValue("result_o", result_o, '0);
		checkValue("shutter_o", 32'(shutter_o), '0);
		checkValue("pipeOutData_o", 32'(pipeOutData_o), 32'(word[15:0]));

		rand32 = lcgNext();
		dioValue = rand32[31:16];

		// system group followed by error words and the shutter
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_PPCLK, '0), `PP_CLK_MHZ, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_FWVER, '0), `FW_VERSION, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_FWDATE, '0), `FW_VERSION, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_MODULE, '0), `MODULE_MASK, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_FWTIME, '0), `FW_VERSION, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_DDSCLK, '0), `DDS_CLK_MHZ, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_RESET, '0), '0, '0);
		addEntry(makeCmd(hostIfPkg::CMD_SYS, 8'h07, '0), `ERR_WORD, '0);
		addEntry(makeCmd(8'h02, 8'h00, '0), `ERR_WORD, '0);
		addEntry(makeCmd(hostIfPkg::CMD_DIG, 8'h07, '0), `ERR_WORD, '0);
		// write keeps the previous answer
		addEntry(makeCmd(hostIfPkg::CMD_DIG, hostIfPkg::DIG_WRITE, dioValue), `ERR_WORD,
			dioValue[`DIO_NUM-1:0]);
		addEntry(makeCmd(hostIfPkg::CMD_DIG, hostIfPkg::DIG_READ, '0),
			32'(dioValue[`DIO_NUM-1:0]), dioValue[`DIO_NUM-1:0]);

		for (int i = 0; i < cmdTable.size(); i++)
		begin
			runCommand(cmdTable[i], expResult[i], expShutter[i]);
		end

		////////////////////////////////////////
		// pipe round trip
		////////////////////////////////////////

		rand32 = lcgNext();
		startAddr = rand32[`MEM_ADDR_W+15:16];
		pplCmd = makeCmd(hostIfPkg::CMD_PPL, hostIfPkg::PPL_ADDR, 16'(startAddr));
		runCommand(pplCmd, 32'(startAddr), dioValue[`DIO_NUM-1:0]);

		for (int i = 0; i < PIPE_WORDS; i++)
		begin
			rand32 = lcgNext();
			pipeWords[i] = rand32[31:16];
		end
		// back to back halves with the low half first
		for (int i = 0; i < PIPE_WORDS; i++)
		begin
			pipeInWrite_i = 1'b1;
			pipeInData_i = pipeWords[i];
			waitCycles(1);
		end
		pipeInWrite_i = 1'b0;

		// rewind the read side
		pulseTrigger(pplCmd);
		checkValue("result_o", result_o, 32'(startAddr));
		// the accepted command starts a restart pulse
		checkValue("pipeCtrl.restart", 32'(dut0.pipeCtrl.restart), 32'd1);
		waitRestartEnd();
		waitCycles(3);

		for (int i = 0; i < PIPE_WORDS; i++)
		begin
			checkValue("pipeOutData_o", 32'(pipeOutData_o), 32'(pipeWords[i]));
			pipeOutRead_i = 1'b1;
			waitCycles(1);
		end
		pipeOutRead_i = 1'b0;

		////////////////////////////////////////
		// trigger during WAIT
		////////////////////////////////////////

		rand32 = lcgNext();
		secondAddr = rand32[`MEM_ADDR_W+15:16];
		pulseTrigger(makeCmd(hostIfPkg::CMD_PPL, hostIfPkg::PPL_ADDR, 16'(secondAddr)));
		checkValue("result_o", result_o, 32'(secondAddr));
		// lands in the WAIT cycle
		pulseTrigger(makeCmd(hostIfPkg::CMD_SYS, hostIfPkg::SYS_FWVER, '0));
		checkValue("result_o", result_o, 32'(secondAddr));
		waitCycles(2);
		checkValue("result_o", result_o, 32'(secondAddr));

		errorCount += dut0.assert0.failCount;
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+.
hostIfPkg.sv
hostCmdDecoder.sv
pipeInPacker.sv
pulseMemory.sv
pipeOutUnpacker.sv
hostCore.sv
hostCore_assertions.sv
hostCore_tb.sv

//--- Makefile
# Verilator build and run for the host core testbench

VERILATOR ?= verilator
TOP ?= hostCore_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
